// File: env_monitor.sv
// Sensor monitor: ADC code scaling, registered value and limit alarm
`timescale 1ns/10ps
`default_nettype none

module env_monitor #(
    parameter int SCALE       = 500,        // Full-scale multiplier
    parameter bit ALARM_ABOVE = 1'b1        // 1: alarm above limit, 0: below
) (
    input  wire                             clk_main,
    input  wire                             rst_n,
    input  wire  [tsn_mgmt_pkg::ADC_W-1:0]  adc_code,   // Raw sensor code
    input  wire  [tsn_mgmt_pkg::VAL_W-1:0]  limit,      // Run-time threshold
    output logic [tsn_mgmt_pkg::VAL_W-1:0]  value,      // Converted reading
    output logic                            alarm
);

    localparam int AW = tsn_mgmt_pkg::ADC_W;
    localparam int VW = tsn_mgmt_pkg::VAL_W;
    localparam int PW = AW + VW;            // Product width, room for any 16-bit scale

    logic [PW-1:0] product;
    logic [VW-1:0] value_next;
    logic          alarm_next;

    // code * SCALE / 2^ADC_W
    assign product    = {{VW{1'b0}}, adc_code} * PW'(SCALE);
    assign value_next = product[PW-1:AW];   // Drop the fraction bits

    // Compare the fresh value so alarm lines up with value
    always_comb begin
        if (ALARM_ABOVE) begin
            alarm_next = (value_next > limit);   // Over-temperature style
        end else begin
            alarm_next = (value_next < limit);   // Under-voltage style
        end
    end

    always_ff @(posedge clk_main or negedge rst_n) begin
        if (!rst_n) begin
            value <= '0;
            alarm <= 1'b0;
        end else begin
            value <= value_next;            // One cycle from sensor to register
            alarm <= alarm_next;
        end
    end

    // A rising alarm must come with a value past the limit seen on that edge
    property p_alarm_rise_unsafe;
        @(posedge clk_main) disable iff (!rst_n)
        $rose(alarm) |-> (ALARM_ABOVE ? (value > $past(limit)) : (value < $past(limit)));
    endproperty
    a_alarm_rise_unsafe: assert property (p_alarm_rise_unsafe)
        else $error("env_monitor: alarm rose with value 0x%h on safe side", value);

endmodule

`default_nettype wire

// File: flist.f
tsn_mgmt_pkg.sv
env_monitor.sv
mgmt_axil_regs.sv
mgmt_status.sv
tsn_mgmt_top.sv
tb_tsn_mgmt.sv

// File: mgmt_axil_regs.sv
// AXI4-Lite register bank: register map, byte strobes, read mux, IRQ clear pulse, responses
`timescale 1ns/10ps
`default_nettype none

module mgmt_axil_regs (
    input  wire                                   clk_main,
    input  wire                                   rst_n,
    // Write address channel
    input  wire  [tsn_mgmt_pkg::ADDR_W-1:0]       s_axil_awaddr,
    input  wire                                   s_axil_awvalid,
    output logic                                  s_axil_awready,
    // Write data channel
    input  wire  [tsn_mgmt_pkg::DATA_W-1:0]       s_axil_wdata,
    input  wire  [tsn_mgmt_pkg::DATA_W/8-1:0]     s_axil_wstrb,
    input  wire                                   s_axil_wvalid,
    output logic                                  s_axil_wready,
    // Write response channel
    output tsn_mgmt_pkg::axil_resp_e              s_axil_bresp,
    output logic                                  s_axil_bvalid,
    input  wire                                   s_axil_bready,
    // Read address channel
    input  wire  [tsn_mgmt_pkg::ADDR_W-1:0]       s_axil_araddr,
    input  wire                                   s_axil_arvalid,
    output logic                                  s_axil_arready,
    // Read data channel
    output logic [tsn_mgmt_pkg::DATA_W-1:0]       s_axil_rdata,
    output tsn_mgmt_pkg::axil_resp_e              s_axil_rresp,
    output logic                                  s_axil_rvalid,
    input  wire                                   s_axil_rready,
    // Status inputs
    input  wire  [tsn_mgmt_pkg::VAL_W-1:0]        temperature,
    input  wire  [tsn_mgmt_pkg::VAL_W-1:0]        voltage,
    input  wire  [tsn_mgmt_pkg::NUM_IRQ-1:0]      irq_status,
    input  wire  [tsn_mgmt_pkg::DATA_W-1:0]       uptime,
    // Configuration outputs
    output logic [tsn_mgmt_pkg::VAL_W-1:0]        temp_limit,
    output logic [tsn_mgmt_pkg::VAL_W-1:0]        volt_min,
    output logic [tsn_mgmt_pkg::NUM_IRQ-1:0]      irq_enable,
    output logic [tsn_mgmt_pkg::NUM_IRQ-1:0]      irq_clear,     // W1C pulse
    output logic [tsn_mgmt_pkg::NUM_PORTS-1:0]    port_power_ctrl
);

    localparam int DW = tsn_mgmt_pkg::DATA_W;
    localparam int AW = tsn_mgmt_pkg::ADDR_W;
    localparam int NI = tsn_mgmt_pkg::NUM_IRQ;
    localparam int NP = tsn_mgmt_pkg::NUM_PORTS;
    localparam int VW = tsn_mgmt_pkg::VAL_W;

    logic          wr_accept;
    logic          rd_accept;
    logic [AW-1:0] wr_addr;                 // Word aligned
    logic [AW-1:0] rd_addr;
    logic [DW-1:0] wr_old;                  // Current content of target register
    logic [DW-1:0] wr_merged;               // After byte strobes
    logic [DW-1:0] rd_mux;

    // Byte-lane merge of write data into the old value
    function automatic logic [DW-1:0] merge_strb(
        input logic [DW-1:0]   old_val,
        input logic [DW-1:0]   new_val,
        input logic [DW/8-1:0] strb
    );
        logic [DW-1:0] result;
        result = old_val;
        for (int b = 0; b < DW/8; b++) begin
            if (strb[b]) result[8*b +: 8] = new_val[8*b +: 8];
        end
        return result;
    endfunction

    // Both halves of a write accepted together, one at a time
    assign wr_accept      = s_axil_awvalid && s_axil_wvalid && !s_axil_bvalid;
    assign s_axil_awready = wr_accept;
    assign s_axil_wready  = wr_accept;
    assign rd_accept      = s_axil_arvalid && !s_axil_rvalid;
    assign s_axil_arready = rd_accept;

    assign wr_addr = {s_axil_awaddr[AW-1:2], 2'b00};
    assign rd_addr = {s_axil_araddr[AW-1:2], 2'b00};

    always_comb begin
        case (wr_addr)
            tsn_mgmt_pkg::REG_CTRL:       wr_old = DW'(irq_enable);
            tsn_mgmt_pkg::REG_PORT_POWER: wr_old = DW'(port_power_ctrl);
            tsn_mgmt_pkg::REG_TEMP_LIMIT: wr_old = DW'(temp_limit);
            tsn_mgmt_pkg::REG_VOLT_MIN:   wr_old = DW'(volt_min);
            default:                      wr_old = '0;   // IRQ_STATUS merges onto zero
        endcase
    end

    assign wr_merged = merge_strb(wr_old, s_axil_wdata, s_axil_wstrb);

    // Clear hits status on the handshake edge, so a following read sees it
    assign irq_clear = (wr_accept && wr_addr == tsn_mgmt_pkg::REG_IRQ_STATUS) ?
                       wr_merged[NI-1:0] : '0;

    // Writable registers and write response
    always_ff @(posedge clk_main or negedge rst_n) begin
        if (!rst_n) begin
            irq_enable      <= tsn_mgmt_pkg::CTRL_RESET;
            port_power_ctrl <= tsn_mgmt_pkg::PORT_POWER_RESET;
            temp_limit      <= tsn_mgmt_pkg::TEMP_LIMIT_RESET;
            volt_min        <= tsn_mgmt_pkg::VOLT_MIN_RESET;
            s_axil_bvalid   <= 1'b0;
            s_axil_bresp    <= tsn_mgmt_pkg::RESP_OKAY;
        end else begin
            if (wr_accept) begin
                case (wr_addr)
                    tsn_mgmt_pkg::REG_CTRL:       irq_enable      <= wr_merged[NI-1:0];
                    tsn_mgmt_pkg::REG_PORT_POWER: port_power_ctrl <= wr_merged[NP-1:0];
                    tsn_mgmt_pkg::REG_TEMP_LIMIT: temp_limit      <= wr_merged[VW-1:0];
                    tsn_mgmt_pkg::REG_VOLT_MIN:   volt_min        <= wr_merged[VW-1:0];
                    default: ;                                   // RO or W1C, nothing stored
                endcase
                s_axil_bvalid <= 1'b1;
                s_axil_bresp  <= (wr_addr > tsn_mgmt_pkg::REG_UPTIME) ?
                                 tsn_mgmt_pkg::RESP_SLVERR : tsn_mgmt_pkg::RESP_OKAY;
            end else if (s_axil_bready) begin
                s_axil_bvalid <= 1'b0;               // Response taken
            end
        end
    end

    // Read mux, narrow fields zero-extended
    always_comb begin
        case (rd_addr)
            tsn_mgmt_pkg::REG_CTRL:        rd_mux = DW'(irq_enable);
            tsn_mgmt_pkg::REG_PORT_POWER:  rd_mux = DW'(port_power_ctrl);
            tsn_mgmt_pkg::REG_TEMP_LIMIT:  rd_mux = DW'(temp_limit);
            tsn_mgmt_pkg::REG_VOLT_MIN:    rd_mux = DW'(volt_min);
            tsn_mgmt_pkg::REG_IRQ_STATUS:  rd_mux = DW'(irq_status);
            tsn_mgmt_pkg::REG_TEMPERATURE: rd_mux = DW'(temperature);
            tsn_mgmt_pkg::REG_VOLTAGE:     rd_mux = DW'(voltage);
            tsn_mgmt_pkg::REG_UPTIME:      rd_mux = uptime;
            default:                       rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk_main or negedge rst_n) begin
        if (!rst_n) begin
            s_axil_rvalid <= 1'b0;
            s_axil_rresp  <= tsn_mgmt_pkg::RESP_OKAY;
        end else if (rd_accept) begin
            s_axil_rvalid <= 1'b1;
            s_axil_rresp  <= (rd_addr > tsn_mgmt_pkg::REG_UPTIME) ?
                             tsn_mgmt_pkg::RESP_SLVERR : tsn_mgmt_pkg::RESP_OKAY;
        end else if (s_axil_rready) begin
            s_axil_rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk_main) begin
        if (rd_accept) s_axil_rdata <= rd_mux;   // Held until next accept
    end

    // Handshake holds under back-pressure
    a_bvalid_hold: assert property (@(posedge clk_main) disable iff (!rst_n)
        s_axil_bvalid && !s_axil_bready |=> s_axil_bvalid)
        else $error("mgmt_axil_regs: bvalid dropped before bready");
    a_rvalid_hold: assert property (@(posedge clk_main) disable iff (!rst_n)
        s_axil_rvalid && !s_axil_rready |=> s_axil_rvalid && $stable(s_axil_rdata))
        else $error("mgmt_axil_regs: rvalid or rdata changed before rready");

endmodule

`default_nettype wire

// File: mgmt_status.sv
// System status: uptime counter, sticky IRQ causes, irq_n and power_good
`timescale 1ns/10ps
`default_nettype none

module mgmt_status (
    input  wire                                 clk_main,
    input  wire                                 rst_n,
    input  wire                                 over_temp,      // Temp monitor alarm
    input  wire                                 under_volt,     // Voltage monitor alarm
    input  wire  [tsn_mgmt_pkg::NUM_PORTS-1:0]  port_tx_error,
    input  wire  [tsn_mgmt_pkg::NUM_IRQ-1:0]    irq_enable,
    input  wire  [tsn_mgmt_pkg::NUM_IRQ-1:0]    irq_clear,      // One-cycle W1C
    output logic [tsn_mgmt_pkg::NUM_IRQ-1:0]    irq_status,
    output logic [tsn_mgmt_pkg::DATA_W-1:0]     uptime,
    output logic                                irq_n,
    output logic                                power_good
);

    logic [tsn_mgmt_pkg::NUM_IRQ-1:0] cause;

    // Raw conditions, one bit per cause
    always_comb begin
        cause = '0;
        cause[tsn_mgmt_pkg::IRQ_OVERTEMP]  = over_temp;
        cause[tsn_mgmt_pkg::IRQ_UNDERVOLT] = under_volt;
        cause[tsn_mgmt_pkg::IRQ_PORT_ERR]  = |port_tx_error;    // Any port
    end

    always_ff @(posedge clk_main or negedge rst_n) begin
        if (!rst_n) begin
            irq_status <= '0;
        end else begin
            irq_status <= (irq_status & ~irq_clear) | cause;     // Set wins over clear
        end
    end

    // Free-running, wraps after 2^32 cycles
    always_ff @(posedge clk_main or negedge rst_n) begin
        if (!rst_n) begin
            uptime <= '0;
        end else begin
            uptime <= uptime + 1'b1;
        end
    end

    assign irq_n      = ~|(irq_status & irq_enable);   // Active low, masked
    assign power_good = ~under_volt;

    // Sticky: a set bit only falls after a clear from the register bank
    a_sticky_cause: assert property (@(posedge clk_main) disable iff (!rst_n)
        (($past(irq_status) & ~irq_status & ~$past(irq_clear)) == '0))
        else $error("mgmt_status: cause bit fell without clear, status 0x%h", irq_status);

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# Build the management testbench with Verilator, run it and judge the result from its output

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    --top-module tb_tsn_mgmt -f flist.f -o sim_tsn_mgmt \
    && ./obj_dir/sim_tsn_mgmt | tee /dev/stderr | grep -F "*** TEST PASSED ***" > /dev/null \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }

// File: tb_tsn_mgmt.sv
// Testbench for the management top level: clock, reset, AXI4-Lite tasks, vector replay, timeout
`timescale 1ns/10ps
`default_nettype none

module tb_tsn_mgmt;

    localparam string VEC_FILE     = "tsn_mgmt_input.txt";
    localparam int    RESET_CYCLES = 10;
    localparam int    CYC_PER_VEC  = 40;    // Generous bound for one vector line
    localparam int    SETTLE       = 6;     // Margin over sensor to sticky bit

    logic        clk_main = 1'b0;
    logic        rst_n;
    logic [7:0]  s_axil_awaddr;
    logic        s_axil_awvalid, s_axil_awready;
    logic [31:0] s_axil_wdata;
    logic [3:0]  s_axil_wstrb;
    logic        s_axil_wvalid, s_axil_wready;
    logic [1:0]  s_axil_bresp;
    logic        s_axil_bvalid, s_axil_bready;
    logic [7:0]  s_axil_araddr;
    logic        s_axil_arvalid, s_axil_arready;
    logic [31:0] s_axil_rdata;
    logic [1:0]  s_axil_rresp;
    logic        s_axil_rvalid, s_axil_rready;
    logic [11:0] temp_adc, volt_adc;
    logic [3:0]  port_tx_error;
    logic        irq_n, power_good;
    logic [3:0]  port_power_ctrl;

    integer      seed        = 18727;       // Back-pressure pattern
    int          fd;
    int          cycle_cnt   = 0;
    int          cycle_limit = RESET_CYCLES + CYC_PER_VEC;  // Raised once the file is counted
    int          num_tests   = 0;
    int          num_errors  = 0;
    logic [31:0] last_uptime = '0;
    int          awready_cnt = 0;           // Rising edges with ready high
    int          wready_cnt  = 0;
    int          arready_cnt = 0;
    int          wr_issued   = 0;           // Transfers started so far
    int          rd_issued   = 0;

    tsn_mgmt_top i_dut (.*);

    always #5 clk_main = ~clk_main;         // 10 ns period

    // Abort a stuck run
    always @(posedge clk_main) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            $display("Timeout after %0d cycles, DUT stopped responding", cycle_cnt);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // One ready pulse per transfer
    always @(posedge clk_main) begin
        if (s_axil_awready) awready_cnt <= awready_cnt + 1;
        if (s_axil_wready)  wready_cnt  <= wready_cnt + 1;
        if (s_axil_arready) arready_cnt <= arready_cnt + 1;
    end

    // Skips the rest of a text line
    task automatic skip_line();
        int c;
        c = 0;
        while (c != 10 && c != -1) begin
            c = $fgetc(fd);
        end
    endtask

    // 0..3 idle cycles before taking a response
    task automatic ready_delay();
        int n;
        n = $random(seed) & 3;
        repeat (n) @(negedge clk_main);
    endtask

    // Ready pulse count against transfers issued
    function automatic int check_pulses(input string name, input int seen, input int issued);
        if (seen != issued) begin
            $display("FAILED %s: got 0x%0h pulses, expected 0x%0h", name, seen, issued);
            return 1;
        end
        return 0;
    endfunction

    // Starts and ends on a falling edge
    task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
                              input logic [3:0] strb, output logic [1:0] resp);
        s_axil_awaddr  = addr;
        s_axil_wdata   = data;
        s_axil_wstrb   = strb;
        s_axil_awvalid = 1'b1;
        s_axil_wvalid  = 1'b1;
        @(negedge clk_main);
        while (!s_axil_bvalid) @(negedge clk_main);   // Handshake was on the edge before
        s_axil_awvalid = 1'b0;
        s_axil_wvalid  = 1'b0;
        resp = s_axil_bresp;
        ready_delay();                       // bvalid held meanwhile
        s_axil_bready = 1'b1;
        @(negedge clk_main);
        s_axil_bready = 1'b0;
    endtask

    task automatic axil_read(input logic [7:0] addr, output logic [31:0] data,
                             output logic [1:0] resp);
        s_axil_araddr  = addr;
        s_axil_arvalid = 1'b1;
        @(negedge clk_main);
        while (!s_axil_rvalid) @(negedge clk_main);
        s_axil_arvalid = 1'b0;
        data = s_axil_rdata;
        resp = s_axil_rresp;
        ready_delay();
        s_axil_rready = 1'b1;
        @(negedge clk_main);
        s_axil_rready = 1'b0;
    endtask

    // Sensor registers follow code * full scale / 4096, others come from the file
    function automatic logic [31:0] expected_read(input logic [7:0] addr,
                                                  input logic [31:0] file_val);
        if (addr == tsn_mgmt_pkg::REG_TEMPERATURE) begin
            return (32'(temp_adc) * 32'd500) >> 12;
        end else if (addr == tsn_mgmt_pkg::REG_VOLTAGE) begin
            return (32'(volt_adc) * 32'd3300) >> 12;
        end
        return file_val;
    endfunction

    initial begin
        logic [7:0]  op;
        logic [31:0] f1, f2, f3, f4;
        logic [31:0] rd_data, exp_data;
        logic [1:0]  resp;
        int          n_vec, code, test_err;
        rst_n          = 1'b0;
        s_axil_awaddr  = '0;
        s_axil_awvalid = 1'b0;
        s_axil_wdata   = '0;
        s_axil_wstrb   = '0;
        s_axil_wvalid  = 1'b0;
        s_axil_bready  = 1'b0;
        s_axil_araddr  = '0;
        s_axil_arvalid = 1'b0;
        s_axil_rready  = 1'b0;
        temp_adc       = 12'h200;           // About 62 C under the limit
        volt_adc       = 12'hF00;           // About 3093 mV over the minimum
        port_tx_error  = '0;
        fd = $fopen(VEC_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open vector file %s", VEC_FILE);
            num_errors++;
        end else begin
            n_vec = 0;                       // First pass sizes the timeout
            while ($fscanf(fd, " %c", op) == 1) begin
                if (op != "#") n_vec++;
                skip_line();
            end
            $fclose(fd);
            cycle_limit = RESET_CYCLES + CYC_PER_VEC * n_vec;
            fd = $fopen(VEC_FILE, "r");
            repeat (RESET_CYCLES) @(negedge clk_main);
            rst_n = 1'b1;
            @(negedge clk_main);
            while ($fscanf(fd, " %c", op) == 1) begin
                if (op == "#") begin
                    skip_line();
                end else begin
                    code = $fscanf(fd, "%h %h %h %h", f1, f2, f3, f4);
                    num_tests++;
                    test_err = 0;
                    if (code != 4) begin
                        $display("Vector %0d is missing fields", num_tests);
                        test_err++;
                    end else begin
                        case (op)
                            "W": begin
                                axil_write(f1[7:0], f2, f3[3:0], resp);
                                wr_issued++;
                                if (resp !== f4[1:0]) begin
                                    $display("FAILED s_axil_bresp: got 0x%h, expected 0x%h",
                                             resp, f4[1:0]);
                                    test_err++;
                                end
                                test_err += check_pulses("s_axil_awready", awready_cnt, wr_issued);
                                test_err += check_pulses("s_axil_wready", wready_cnt, wr_issued);
                            end
                            "R": begin
                                axil_read(f1[7:0], rd_data, resp);
                                rd_issued++;
                                if (f1[7:0] == tsn_mgmt_pkg::REG_UPTIME) begin
                                    if (rd_data <= last_uptime) begin
                                        $display("FAILED s_axil_rdata: got 0x%08h, previous 0x%08h",
                                                 rd_data, last_uptime);
                                        test_err++;
                                    end
                                    last_uptime = rd_data;
                                end else begin
                                    exp_data = expected_read(f1[7:0], f2);
                                    if (rd_data !== exp_data) begin
                                        $display("FAILED s_axil_rdata: got 0x%08h, expected 0x%08h",
                                                 rd_data, exp_data);
                                        test_err++;
                                    end
                                end
                                if (resp !== f4[1:0]) begin
                                    $display("FAILED s_axil_rresp: got 0x%h, expected 0x%h",
                                             resp, f4[1:0]);
                                    test_err++;
                                end
                                test_err += check_pulses("s_axil_arready", arready_cnt, rd_issued);
                            end
                            "S": begin
                                temp_adc      = f1[11:0];
                                volt_adc      = f2[11:0];
                                port_tx_error = f3[3:0];
                                repeat (SETTLE) @(negedge clk_main);   // Value then status
                            end
                            "I": begin
                                if (irq_n !== f1[0]) begin
                                    $display("FAILED irq_n: got 0x%h, expected 0x%h",
                                             irq_n, f1[0]);
                                    test_err++;
                                end
                                if (power_good !== f2[0]) begin
                                    $display("FAILED power_good: got 0x%h, expected 0x%h",
                                             power_good, f2[0]);
                                    test_err++;
                                end
                                if (port_power_ctrl !== f3[3:0]) begin
                                    $display("FAILED port_power_ctrl: got 0x%h, expected 0x%h",
                                             port_power_ctrl, f3[3:0]);
                                    test_err++;
                                end
                            end
                            default: begin
                                $display("Vector %0d has unknown opcode %c", num_tests, op);
                                test_err++;
                            end
                        endcase
                    end
                    num_errors += test_err;
                    $display("Test %0d (%c 0x%08h): %s", num_tests, op, f1,
                             (test_err == 0) ? "ok" : "mismatch");
                end
            end
            $fclose(fd);
        end
        $display("Tests run: %0d, errors: %0d", num_tests, num_errors);
        if (num_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tsn_mgmt_input.txt
# op f1 f2 f3 f4 (hex)  W: addr data strb resp  R: addr data 0 resp (sensors, uptime computed)
# S: temp_adc volt_adc port_err 0  I: irq_n power_good port_power 0
R 00 00000007 0 0
R 04 0000000F 0 0
R 08 00000055 0 0
R 0C 00000BB8 0 0
R 10 00000000 0 0
I 1 1 F 0
W 04 00000005 F 0
I 1 1 5 0
R 04 00000005 0 0
W 08 00000064 1 0
R 08 00000064 0 0
W 14 0000FFFF F 0
R 14 00000000 0 0
W 20 12345678 F 2
R 20 00000000 0 2
S 28F FFF 0 0
R 14 00000000 0 0
R 18 00000000 0 0
S 400 FFF 0 0
S 200 FFF 0 0
R 10 00000001 0 0
I 0 1 5 0
W 10 00000001 F 0
R 10 00000000 0 0
I 1 1 5 0
S 200 FFF 2 0
S 200 FFF 0 0
R 10 00000004 0 0
I 0 1 5 0
W 10 00000004 F 0
W 00 00000000 F 0
S 200 800 0 0
I 1 0 5 0
R 10 00000002 0 0
R 1C 00000000 0 0
R 1C 00000000 0 0

// File: tsn_mgmt_pkg.sv
// Management package: bus and sensor widths, register offsets, reset values, IRQ indices
`default_nettype none

package tsn_mgmt_pkg;

    // Sensor path widths
    localparam int ADC_W = 12;              // Raw ADC code
    localparam int VAL_W = 16;              // Converted value and limits

    // AXI4-Lite bus
    localparam int DATA_W = 32;
    localparam int ADDR_W = 8;

    // Switch ports seen by the management block
    localparam int NUM_PORTS = 4;

    // Interrupt causes
    localparam int NUM_IRQ       = 3;
    localparam int IRQ_OVERTEMP  = 0;
    localparam int IRQ_UNDERVOLT = 1;
    localparam int IRQ_PORT_ERR  = 2;       // OR of all port tx errors

    // Register byte offsets
    localparam logic [ADDR_W-1:0] REG_CTRL        = 8'h00;  // IRQ enables
    localparam logic [ADDR_W-1:0] REG_PORT_POWER  = 8'h04;
    localparam logic [ADDR_W-1:0] REG_TEMP_LIMIT  = 8'h08;
    localparam logic [ADDR_W-1:0] REG_VOLT_MIN    = 8'h0C;
    localparam logic [ADDR_W-1:0] REG_IRQ_STATUS  = 8'h10;  // W1C
    localparam logic [ADDR_W-1:0] REG_TEMPERATURE = 8'h14;  // RO
    localparam logic [ADDR_W-1:0] REG_VOLTAGE     = 8'h18;  // RO
    localparam logic [ADDR_W-1:0] REG_UPTIME      = 8'h1C;  // RO, last valid offset

    // Reset values of the writable registers
    localparam logic [NUM_IRQ-1:0]   CTRL_RESET       = 3'h7;     // All IRQs on
    localparam logic [NUM_PORTS-1:0] PORT_POWER_RESET = 4'hF;     // All ports powered
    localparam logic [VAL_W-1:0]     TEMP_LIMIT_RESET = 16'd85;   // Degrees C
    localparam logic [VAL_W-1:0]     VOLT_MIN_RESET   = 16'd3000; // Millivolts

    // Full-scale multipliers for the ADC conversion
    localparam int TEMP_SCALE = 500;        // 0..500 C over the ADC range
    localparam int VOLT_SCALE = 3300;       // 3.3 V reference

    // AXI response codes
    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axil_resp_e;

endpackage

`default_nettype wire

// File: tsn_mgmt_top.sv
// Management top level: register bank, temperature and voltage monitors, status block
`timescale 1ns/10ps
`default_nettype none

module tsn_mgmt_top #(
    parameter int TEMP_SCALE = tsn_mgmt_pkg::TEMP_SCALE,
    parameter int VOLT_SCALE = tsn_mgmt_pkg::VOLT_SCALE
) (
    input  wire                                 clk_main,
    input  wire                                 rst_n,
    // AXI4-Lite slave
    input  wire  [tsn_mgmt_pkg::ADDR_W-1:0]     s_axil_awaddr,
    input  wire                                 s_axil_awvalid,
    output logic                                s_axil_awready,
    input  wire  [tsn_mgmt_pkg::DATA_W-1:0]     s_axil_wdata,
    input  wire  [tsn_mgmt_pkg::DATA_W/8-1:0]   s_axil_wstrb,
    input  wire                                 s_axil_wvalid,
    output logic                                s_axil_wready,
    output logic [1:0]                          s_axil_bresp,
    output logic                                s_axil_bvalid,
    input  wire                                 s_axil_bready,
    input  wire  [tsn_mgmt_pkg::ADDR_W-1:0]     s_axil_araddr,
    input  wire                                 s_axil_arvalid,
    output logic                                s_axil_arready,
    output logic [tsn_mgmt_pkg::DATA_W-1:0]     s_axil_rdata,
    output logic [1:0]                          s_axil_rresp,
    output logic                                s_axil_rvalid,
    input  wire                                 s_axil_rready,
    // Sensors and switch
    input  wire  [tsn_mgmt_pkg::ADC_W-1:0]      temp_adc,
    input  wire  [tsn_mgmt_pkg::ADC_W-1:0]      volt_adc,
    input  wire  [tsn_mgmt_pkg::NUM_PORTS-1:0]  port_tx_error,
    // System outputs
    output logic                                irq_n,
    output logic                                power_good,
    output logic [tsn_mgmt_pkg::NUM_PORTS-1:0]  port_power_ctrl
);

    logic [tsn_mgmt_pkg::VAL_W-1:0]   temp_limit;   // Bank to monitors
    logic [tsn_mgmt_pkg::VAL_W-1:0]   volt_min;
    logic [tsn_mgmt_pkg::VAL_W-1:0]   temperature;  // Monitors to bank
    logic [tsn_mgmt_pkg::VAL_W-1:0]   voltage;
    logic                             over_temp;
    logic                             under_volt;
    logic [tsn_mgmt_pkg::NUM_IRQ-1:0] irq_enable;
    logic [tsn_mgmt_pkg::NUM_IRQ-1:0] irq_clear;
    logic [tsn_mgmt_pkg::NUM_IRQ-1:0] irq_status;
    logic [tsn_mgmt_pkg::DATA_W-1:0]  uptime;

    mgmt_axil_regs i_regs (
        .clk_main, .rst_n,
        .s_axil_awaddr, .s_axil_awvalid, .s_axil_awready,
        .s_axil_wdata, .s_axil_wstrb, .s_axil_wvalid, .s_axil_wready,
        .s_axil_bresp, .s_axil_bvalid, .s_axil_bready,
        .s_axil_araddr, .s_axil_arvalid, .s_axil_arready,
        .s_axil_rdata, .s_axil_rresp, .s_axil_rvalid, .s_axil_rready,
        .temperature, .voltage, .irq_status, .uptime,
        .temp_limit, .volt_min, .irq_enable, .irq_clear, .port_power_ctrl
    );

    // Temperature alarms above its limit
    env_monitor #(.SCALE(TEMP_SCALE), .ALARM_ABOVE(1'b1)) i_temp_mon (
        .clk_main, .rst_n,
        .adc_code(temp_adc), .limit(temp_limit), .value(temperature), .alarm(over_temp)
    );

    // Supply alarms below its minimum
    env_monitor #(.SCALE(VOLT_SCALE), .ALARM_ABOVE(1'b0)) i_volt_mon (
        .clk_main, .rst_n,
        .adc_code(volt_adc), .limit(volt_min), .value(voltage), .alarm(under_volt)
    );

    mgmt_status i_status (
        .clk_main, .rst_n,
        .over_temp, .under_volt, .port_tx_error, .irq_enable, .irq_clear,
        .irq_status, .uptime, .irq_n, .power_good
    );

endmodule

`default_nettype wire
